// File: filelist.f
source/xbar_cfg_pkg.sv
source/xbar_types_pkg.sv
source/xbar_req_if.sv
source/req_decoder.sv
source/bank_arbiter.sv
source/rsp_router.sv
source/xbar_top.sv
tests/xbar_properties.sv
tests/tb_xbar.sv

// File: source/bank_arbiter.sv
// Round-robin arbiter in front of one bank port
// Picks among decoded requests aimed at this bank and holds the
// granted request with its source tag until the bank accepts it

`timescale 1ns/1ns

module bank_arbiter #(
  parameter int NumReq  = 2,
  parameter int NumBank = 4,
  parameter int BankIdx = 0
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     bank_req_ready_i,
  xbar_req_if.arbiter              reqs [NumReq],
  output logic                     bank_req_valid_o,
  output xbar_types_pkg::mem_req_t bank_req_o,
  output xbar_types_pkg::req_idx_t bank_id_o
);
  import xbar_types_pkg::*;

  logic     [NumReq-1:0] pending;  // Valid and aimed at this bank
  logic     [NumReq-1:0] gnt;
  mem_req_t [NumReq-1:0] req_in;
  logic                  load;     // Output register free this cycle
  logic                  found;
  req_idx_t              sel;

  logic                  valid_q;
  mem_req_t              req_q;
  req_idx_t              id_q;
  req_idx_t              last_q;   // Last granted requester

  if (BankIdx >= NumBank) begin : gen_idx_check
    $error("bank_arbiter: BankIdx %0d outside of %0d banks", BankIdx, NumBank);
  end

  for (genvar i = 0; i < NumReq; i++) begin : gen_port
    assign pending[i] = reqs[i].valid && (reqs[i].bank == bank_idx_t'(BankIdx));
    assign req_in[i]  = reqs[i].req;
    assign reqs[i].ready_bank[BankIdx] = gnt[i] && load;
  end

  assign load = !valid_q || bank_req_ready_i;

  // Search starts one past the last winner
  always_comb begin : proc_rr
    int idx;
    gnt   = '0;
    found = 1'b0;
    sel   = last_q;
    for (int k = 1; k <= NumReq; k++) begin
      idx = (int'(last_q) + k) % NumReq;
      if (!found && pending[idx]) begin
        found    = 1'b1;
        gnt[idx] = 1'b1;
        sel      = req_idx_t'(idx);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : proc_ctrl
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      last_q  <= req_idx_t'(NumReq - 1);  // Requester 0 goes first
    end else if (load) begin
      valid_q <= found;
      if (found) begin
        last_q <= sel;
      end
    end
  end

  always_ff @(posedge clk_i) begin : proc_payload
    if (load && found) begin
      req_q <= req_in[sel];
      id_q  <= sel;  // Source tag, echoed back by the bank
    end
  end

  assign bank_req_valid_o = valid_q;
  assign bank_req_o       = req_q;
  assign bank_id_o        = id_q;

endmodule : bank_arbiter

// File: source/req_decoder.sv
// Request decoder for one requester port
// Rule table lookup or interleaved bank select, bank field strip,
// decode error pulse and single outstanding request tracking

`timescale 1ns/1ns

module req_decoder #(
  parameter int NumBank  = 4,
  parameter int NumRules = 4
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic                                      interleave_en_i,
  input  xbar_types_pkg::addr_rule_t [NumRules-1:0] addr_map_i,
  input  logic                                      req_valid_i,
  input  xbar_types_pkg::mem_req_t                  req_i,
  input  logic                                      done_i,     // Response pulse for this port
  output logic                                      req_ready_o,
  output logic                                      err_o,
  xbar_req_if.decoder                               dec
);
  import xbar_cfg_pkg::*;
  import xbar_types_pkg::*;

  localparam int BankW   = (NumBank > 1) ? $clog2(NumBank) : 1;
  localparam int SelHigh = BANK_SEL_LOW + BankW;  // First address bit above the bank field

  logic      accept;
  logic      rule_hit;
  bank_idx_t rule_bank;
  bank_idx_t dec_bank;
  addr_t     dec_addr;
  logic      dec_err;

  logic      busy_q;
  logic      valid_q;
  logic      err_q;
  mem_req_t  req_q;
  bank_idx_t bank_q;

  assign req_ready_o = !busy_q;
  assign accept      = req_valid_i && !busy_q;

  // Later rules win, so the highest matching rule sets the bank
  always_comb begin : proc_rule_match
    rule_hit  = 1'b0;
    rule_bank = '0;
    for (int r = 0; r < NumRules; r++) begin
      if (req_i.addr >= addr_map_i[r].start_addr && req_i.addr < addr_map_i[r].end_addr) begin
        rule_hit  = 1'b1;
        rule_bank = addr_map_i[r].idx;
      end
    end
  end

  always_comb begin : proc_select
    if (interleave_en_i) begin
      dec_bank = bank_idx_t'(req_i.addr[BANK_SEL_LOW +: BankW]);
      // Close the gap left by the bank field, zeros at the top
      dec_addr = {{BankW{1'b0}},
                  req_i.addr[ADDR_WIDTH-1:SelHigh],
                  req_i.addr[BANK_SEL_LOW-1:0]};
      dec_err  = 1'b0;
    end else begin
      dec_bank = rule_bank;
      dec_addr = req_i.addr;
      dec_err  = !rule_hit || (int'(rule_bank) >= NumBank);  // Rule pointing past last bank
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : proc_ctrl
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      err_q <= accept && dec_err;  // One cycle pulse to the router
      if (accept) begin
        busy_q  <= 1'b1;
        valid_q <= !dec_err;
      end else begin
        if (done_i) begin
          busy_q <= 1'b0;
        end
        if (valid_q && dec.ready) begin
          valid_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin : proc_payload
    if (accept) begin
      req_q  <= '{write: req_i.write, addr: dec_addr, data: req_i.data};
      bank_q <= dec_bank;
    end
  end

  assign dec.valid = valid_q;
  assign dec.req   = req_q;
  assign dec.bank  = bank_q;
  assign err_o     = err_q;

endmodule : req_decoder

// File: source/rsp_router.sv
// Response router
// Steers tagged bank responses and decode errors back to their
// requesters as registered one-cycle pulses

`timescale 1ns/1ns

module rsp_router #(
  parameter int NumReq  = 2,
  parameter int NumBank = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                     [NumReq-1:0]   err_i,  // Decode error per requester
  input  logic                     [NumBank-1:0]  bank_rsp_valid_i,
  input  xbar_types_pkg::req_idx_t [NumBank-1:0]  bank_rsp_id_i,
  input  xbar_types_pkg::data_t    [NumBank-1:0]  bank_rsp_rdata_i,
  output logic                     [NumReq-1:0]   rsp_valid_o,
  output xbar_types_pkg::data_t    [NumReq-1:0]   rsp_rdata_o,
  output logic                     [NumReq-1:0]   rsp_err_o
);
  import xbar_types_pkg::*;

  logic  [NumReq-1:0] hit_d;
  data_t [NumReq-1:0] rdata_d;

  logic  [NumReq-1:0] valid_q;
  logic  [NumReq-1:0] err_q;
  data_t [NumReq-1:0] rdata_q;

  // Each requester has one request in flight, so at most one source hits
  always_comb begin : proc_route
    hit_d   = err_i;
    rdata_d = '0;  // Decode errors and idle ports read zero
    for (int r = 0; r < NumReq; r++) begin
      for (int b = 0; b < NumBank; b++) begin
        if (bank_rsp_valid_i[b] && (bank_rsp_id_i[b] == req_idx_t'(r))) begin
          hit_d[r]   = 1'b1;
          rdata_d[r] = bank_rsp_rdata_i[b];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : proc_ctrl
    if (!rst_n_i) begin
      valid_q <= '0;
      err_q   <= '0;
    end else begin
      valid_q <= hit_d;
      err_q   <= err_i;
    end
  end

  always_ff @(posedge clk_i) begin : proc_data
    rdata_q <= rdata_d;
  end

  assign rsp_valid_o = valid_q;
  assign rsp_err_o   = err_q;
  assign rsp_rdata_o = rdata_q;

endmodule : rsp_router

// File: source/xbar_cfg_pkg.sv
// Crossbar configuration constants
// Default port and rule counts, bus widths and the interleave field position

package xbar_cfg_pkg;

  // Default sizes, overridden through the top level parameters
  localparam int unsigned NUM_REQ   = 2;
  localparam int unsigned NUM_BANK  = 4;
  localparam int unsigned NUM_RULES = 4;

  // Bus widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;

  // Lowest address bit of the bank field in interleave mode
  localparam int unsigned BANK_SEL_LOW = 16;

  // Width of the index fields that name a bank or a requester
  localparam int unsigned IDX_WIDTH = 8;

endpackage : xbar_cfg_pkg

// File: source/xbar_req_if.sv
// Decoded request link from one requester decoder to all bank arbiters
// Per-bank ready bits are combined into ready at the top level

`timescale 1ns/1ns

interface xbar_req_if #(
  parameter int NumBank = 4
);
  import xbar_types_pkg::*;

  logic              valid;
  logic              ready;       // OR of ready_bank
  mem_req_t          req;
  bank_idx_t         bank;        // Target bank of req
  wire [NumBank-1:0] ready_bank;  // One bit per arbiter

  modport decoder (
    output valid,
    output req,
    output bank,
    input  ready
  );

  modport arbiter (
    input  valid,
    input  req,
    input  bank,
    output ready_bank
  );

endinterface : xbar_req_if

// File: source/xbar_top.sv
// Banked memory crossbar top level
// One decoder per requester, one arbiter per bank and a shared
// response router, joined by the decoded request links

`timescale 1ns/1ns

module xbar_top #(
  parameter int NumReq   = xbar_cfg_pkg::NUM_REQ,
  parameter int NumBank  = xbar_cfg_pkg::NUM_BANK,
  parameter int NumRules = xbar_cfg_pkg::NUM_RULES
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic                                      interleave_en_i,
  input  xbar_types_pkg::addr_rule_t [NumRules-1:0] addr_map_i,
  // Requester ports
  input  logic                       [NumReq-1:0]   req_valid_i,
  input  logic                       [NumReq-1:0]   req_write_i,
  input  xbar_types_pkg::addr_t      [NumReq-1:0]   req_addr_i,
  input  xbar_types_pkg::data_t      [NumReq-1:0]   req_wdata_i,
  output logic                       [NumReq-1:0]   req_ready_o,
  output logic                       [NumReq-1:0]   rsp_valid_o,
  output logic                       [NumReq-1:0]   rsp_err_o,
  output xbar_types_pkg::data_t      [NumReq-1:0]   rsp_rdata_o,
  // Bank ports
  output logic                       [NumBank-1:0]  bank_req_valid_o,
  output logic                       [NumBank-1:0]  bank_write_o,
  output xbar_types_pkg::addr_t      [NumBank-1:0]  bank_addr_o,
  output xbar_types_pkg::data_t      [NumBank-1:0]  bank_wdata_o,
  output xbar_types_pkg::req_idx_t   [NumBank-1:0]  bank_id_o,
  input  logic                       [NumBank-1:0]  bank_req_ready_i,
  input  logic                       [NumBank-1:0]  bank_rsp_valid_i,
  input  xbar_types_pkg::req_idx_t   [NumBank-1:0]  bank_rsp_id_i,
  input  xbar_types_pkg::data_t      [NumBank-1:0]  bank_rsp_rdata_i
);
  import xbar_types_pkg::*;

  mem_req_t [NumReq-1:0]  req_pack;
  logic     [NumReq-1:0]  dec_err;
  mem_req_t [NumBank-1:0] bank_req;

  xbar_req_if #(.NumBank(NumBank)) req_if [NumReq] ();

  for (genvar i = 0; i < NumReq; i++) begin : gen_req
    assign req_pack[i]     = '{write: req_write_i[i], addr: req_addr_i[i], data: req_wdata_i[i]};
    assign req_if[i].ready = |req_if[i].ready_bank;  // Only the target bank can grant

    req_decoder #(
      .NumBank  ( NumBank  ),
      .NumRules ( NumRules )
    ) i_dec (
      .clk_i           ( clk_i           ),
      .rst_n_i         ( rst_n_i         ),
      .interleave_en_i ( interleave_en_i ),
      .addr_map_i      ( addr_map_i      ),
      .req_valid_i     ( req_valid_i[i]  ),
      .req_i           ( req_pack[i]     ),
      .done_i          ( rsp_valid_o[i]  ),
      .req_ready_o     ( req_ready_o[i]  ),
      .err_o           ( dec_err[i]      ),
      .dec             ( req_if[i]       )
    );
  end

  for (genvar b = 0; b < NumBank; b++) begin : gen_bank
    bank_arbiter #(
      .NumReq  ( NumReq  ),
      .NumBank ( NumBank ),
      .BankIdx ( b       )
    ) i_arb (
      .clk_i            ( clk_i               ),
      .rst_n_i          ( rst_n_i             ),
      .bank_req_ready_i ( bank_req_ready_i[b] ),
      .reqs             ( req_if              ),
      .bank_req_valid_o ( bank_req_valid_o[b] ),
      .bank_req_o       ( bank_req[b]         ),
      .bank_id_o        ( bank_id_o[b]        )
    );

    assign bank_write_o[b] = bank_req[b].write;
    assign bank_addr_o[b]  = bank_req[b].addr;
    assign bank_wdata_o[b] = bank_req[b].data;
  end

  rsp_router #(
    .NumReq  ( NumReq  ),
    .NumBank ( NumBank )
  ) i_router (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .err_i            ( dec_err          ),
    .bank_rsp_valid_i ( bank_rsp_valid_i ),
    .bank_rsp_id_i    ( bank_rsp_id_i    ),
    .bank_rsp_rdata_i ( bank_rsp_rdata_i ),
    .rsp_valid_o      ( rsp_valid_o      ),
    .rsp_rdata_o      ( rsp_rdata_o      ),
    .rsp_err_o        ( rsp_err_o        )
  );

endmodule : xbar_top

// File: source/xbar_types_pkg.sv
// Crossbar data types
// Address and data words, the request payload, address rules
// and the index types used for bank select and source tags

package xbar_types_pkg;

  typedef logic [xbar_cfg_pkg::ADDR_WIDTH-1:0] addr_t;
  typedef logic [xbar_cfg_pkg::DATA_WIDTH-1:0] data_t;

  // Bank index, wide enough for every bank count in use
  typedef logic [xbar_cfg_pkg::IDX_WIDTH-1:0] bank_idx_t;

  // Requester index, travels with a request as its source tag
  typedef logic [xbar_cfg_pkg::IDX_WIDTH-1:0] req_idx_t;

  // One read or write request
  typedef struct packed {
    logic  write;  // 1 = write, 0 = read
    addr_t addr;
    data_t data;   // Write data, ignored on reads
  } mem_req_t;

  // Address window [start_addr, end_addr) mapped onto one bank
  typedef struct packed {
    addr_t     start_addr;
    addr_t     end_addr;  // Exclusive
    bank_idx_t idx;
  } addr_rule_t;

endpackage : xbar_types_pkg

// File: tests/tb_xbar.sv
// Crossbar testbench
// Clock, reset, LFSR stimulus, bank memory models, reference decode,
// per-requester comparers and the closing report

`timescale 1ns/1ns

module tb_xbar;
  import xbar_cfg_pkg::*;
  import xbar_types_pkg::*;

  localparam int NR      = NUM_REQ;
  localparam int NB      = NUM_BANK;
  localparam int NRULE   = NUM_RULES;
  localparam int BW      = $clog2(NUM_BANK);
  localparam int TIMEOUT = 500;

  typedef struct packed {
    logic      err;
    bank_idx_t bank;
    addr_t     addr;
  } exp_t;

  logic clk_i, rst_n_i, interleave_en_i;
  addr_rule_t [NRULE-1:0] addr_map_i;
  logic     [NR-1:0] req_valid_i, req_write_i, req_ready_o, rsp_valid_o, rsp_err_o;
  addr_t    [NR-1:0] req_addr_i;
  data_t    [NR-1:0] req_wdata_i, rsp_rdata_o;
  logic     [NB-1:0] bank_req_valid_o, bank_write_o, bank_req_ready_i, bank_rsp_valid_i;
  addr_t    [NB-1:0] bank_addr_o;
  data_t    [NB-1:0] bank_wdata_o, bank_rsp_rdata_i;
  req_idx_t [NB-1:0] bank_id_o, bank_rsp_id_i;

  logic [31:0] lfsr_q = 32'hb38b_c052;
  int    cyc_q = 0;
  int    n_tests = 0, n_checks = 0, err_cnt = 0, err_mark = 0;
  addr_t cur_addr [NR];    // Request in flight per requester
  logic  cur_wr [NR];
  data_t cur_data [NR];
  int    acc_cyc [NR];
  int    hs_cnt [NR];      // Bank handshakes seen for it
  logic  pend_q [NR] = '{default: 1'b0};
  int    pend_bank_q [NR];
  int    last_id_q [NB] = '{default: 0};
  logic  alt_q [NB] = '{default: 1'b0};  // Other requester must win next
  data_t sb_q [addr_t];    // Last data written per address

  xbar_top #(.NumReq(NR), .NumBank(NB), .NumRules(NRULE)) uut (.*);

  initial begin : proc_clk
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc_q <= cyc_q + 1;

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic exp_t ref_decode(input logic ilv, input addr_rule_t [NRULE-1:0] map,
                                      input addr_t a);
    exp_t e;
    e = '{err: 1'b1, bank: '0, addr: a};
    if (ilv) begin
      e.err  = 1'b0;
      e.bank = bank_idx_t'((a >> BANK_SEL_LOW) % NB);
      e.addr = ((a >> (BANK_SEL_LOW + BW)) << BANK_SEL_LOW) | (a % (32'd1 << BANK_SEL_LOW));
    end else begin
      for (int k = 0; k < NRULE; k++) begin
        if (a >= map[k].start_addr && a < map[k].end_addr) begin  // Later rule wins
          e.err  = 1'b0;
          e.bank = map[k].idx;
        end
      end
    end
    return e;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] got);
    n_checks++;
    if (exp !== got) begin
      err_cnt++;
      $display("Error %s exp %0h got %0h", name, exp, got);
    end
  endtask

  task automatic abort_on_timeout(input string what, input int r);
    $display("Timeout: requester %0d waited too long for %s", r, what);
    $display("sim failed");
    $finish;
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("Test %0d %s done with %0d errors", n_tests, name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  // Starts 2 ns after an edge and returns 2 ns after the response edge
  task automatic do_req(input int r, input logic wr, input addr_t a, input data_t d);
    exp_t e;
    int   t;
    e = ref_decode(interleave_en_i, addr_map_i, a);
    cur_addr[r] = a;
    cur_wr[r]   = wr;
    cur_data[r] = d;
    hs_cnt[r]   = 0;
    req_valid_i[r] = 1'b1;
    req_write_i[r] = wr;
    req_addr_i[r]  = a;
    req_wdata_i[r] = d;
    t = 0;
    @(posedge clk_i);
    while (!req_ready_o[r]) begin
      t++;
      if (t > TIMEOUT) abort_on_timeout("acceptance", r);
      @(posedge clk_i);
    end
    acc_cyc[r]     <= cyc_q;
    pend_q[r]      <= !e.err;
    pend_bank_q[r] <= e.bank;
    #2 req_valid_i[r] = 1'b0;
    t = 0;
    @(posedge clk_i);
    while (!rsp_valid_o[r]) begin
      t++;
      if (t > TIMEOUT) abort_on_timeout("a response", r);
      @(posedge clk_i);
    end
    #2;
  endtask

  task automatic write_read(input int r, input addr_t base, input addr_t stride, input int n);
    for (int k = 0; k < n; k++) do_req(r, 1'b1, base + k * stride, take_bits(32));
    for (int k = 0; k < n; k++) do_req(r, 1'b0, base + k * stride, '0);
  endtask

  // Bank memories with random ready and a random 1 to 4 cycle response latency
  for (genvar b = 0; b < NB; b++) begin : gen_bank
    data_t mem_q [addr_t];
    initial begin : proc_model
      int       lat;
      req_idx_t id;
      data_t    rd;
      bank_req_ready_i[b] = 1'b0;
      bank_rsp_valid_i[b] = 1'b0;
      bank_rsp_id_i[b]    = '0;
      bank_rsp_rdata_i[b] = '0;
      forever begin
        @(posedge clk_i);
        if (bank_req_valid_o[b] && bank_req_ready_i[b]) begin
          id = bank_id_o[b];
          rd = '0;
          if (bank_write_o[b]) mem_q[bank_addr_o[b]] = bank_wdata_o[b];
          else if (mem_q.exists(bank_addr_o[b])) rd = mem_q[bank_addr_o[b]];
          lat = 1 + take_bits(2);
          #2 bank_req_ready_i[b] = 1'b0;
          for (int k = 1; k < lat; k++) begin
            @(posedge clk_i);
            #2;
          end
          bank_rsp_valid_i[b] = 1'b1;
          bank_rsp_id_i[b]    = id;
          bank_rsp_rdata_i[b] = rd;
          @(posedge clk_i);
          #2 bank_rsp_valid_i[b] = 1'b0;
          bank_req_ready_i[b] = take_bits(1);
        end else begin
          #2 bank_req_ready_i[b] = take_bits(1);
        end
      end
    end
  end

  for (genvar g = 0; g < NR; g++) begin : gen_cmp
    always @(posedge clk_i) begin : proc_cmp
      exp_t e;
      e = ref_decode(interleave_en_i, addr_map_i, cur_addr[g]);
      for (int b = 0; b < NB; b++) begin
        if (bank_req_valid_o[b] && bank_req_ready_i[b] && bank_id_o[b] == g) begin
          check("bank index", e.bank, b);
          check("bank_addr_o", e.addr, bank_addr_o[b]);
          check("bank_write_o", cur_wr[g], bank_write_o[b]);
          if (cur_wr[g]) check("bank_wdata_o", cur_data[g], bank_wdata_o[b]);
          if (alt_q[b]) check("bank_id_o", (last_id_q[b] + 1) % NR, bank_id_o[b]);
          last_id_q[b] <= g;
          alt_q[b]     <= pend_q[1 - g] && pend_bank_q[1 - g] == b;
          pend_q[g]    <= 1'b0;
          hs_cnt[g]++;
        end
      end
      if (rsp_valid_o[g]) begin
        check("bank request count", !e.err, hs_cnt[g]);
        check("rsp_err_o", e.err, rsp_err_o[g]);
        if (e.err) begin
          check("rsp_rdata_o", '0, rsp_rdata_o[g]);
          check("rsp latency", 2, cyc_q - acc_cyc[g]);
        end else if (cur_wr[g]) begin
          check("rsp_rdata_o", '0, rsp_rdata_o[g]);
          sb_q[cur_addr[g]] = cur_data[g];
        end else begin
          check("rsp_rdata_o", sb_q.exists(cur_addr[g]) ? sb_q[cur_addr[g]] : '0,
                rsp_rdata_o[g]);
        end
      end
    end
  end

  initial begin : proc_main
    rst_n_i = 1'b0;
    interleave_en_i = 1'b0;
    req_valid_i = '0;
    req_write_i = '0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    addr_map_i[0] = '{start_addr: 32'h0000_0000, end_addr: 32'h0001_0000, idx: 8'd0};
    addr_map_i[1] = '{start_addr: 32'h0001_0000, end_addr: 32'h0002_0000, idx: 8'd1};
    addr_map_i[2] = '{start_addr: 32'h0002_0000, end_addr: 32'h0003_0000, idx: 8'd2};
    addr_map_i[3] = '{start_addr: 32'h0002_8000, end_addr: 32'h0004_0000, idx: 8'd3};
    repeat (3) @(posedge clk_i);
    #2 rst_n_i = 1'b1;
    @(posedge clk_i);
    check("bank_req_valid_o", '0, bank_req_valid_o);
    check("rsp_valid_o", '0, rsp_valid_o);
    check("req_ready_o", {NR{1'b1}}, req_ready_o);
    end_test("reset state");
    #2;
    fork
      write_read(0, 32'h0000_0100 + (take_bits(8) << 2), 32'h0001_0000, 4);
      write_read(1, 32'h0000_9100 + (take_bits(8) << 2), 32'h0001_0000, 4);  // Hits overlap
    join
    end_test("rule decode");
    fork
      do_req(0, 1'b1, 32'h0080_0000 + take_bits(12), take_bits(32));
      do_req(1, 1'b0, 32'hf000_0000 + take_bits(12), '0);
    join
    end_test("decode error");
    interleave_en_i = 1'b1;
    fork
      // Upper address bits set so the zero fill shows
      write_read(0, 32'hc100_0000 + (take_bits(10) << 2), 32'h0001_0000, 4);
      write_read(1, 32'hc100_1000 + (take_bits(10) << 2), 32'h0001_0000, 4);
    join
    end_test("interleave");
    interleave_en_i = 1'b0;
    fork
      write_read(0, 32'h0001_2000, 32'h4, 6);  // Both requesters on bank 1
      write_read(1, 32'h0001_3000, 32'h4, 6);
    join
    end_test("contention");
    $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule : tb_xbar

// File: tests/xbar_properties.sv
// Concurrent checks on the crossbar top level handshakes
// Bank request stability, response pulse width, blocked requesters

`timescale 1ns/1ns

module xbar_properties #(
  parameter int NumReq  = 2,
  parameter int NumBank = 4
) (
  input logic                                     clk_i,
  input logic                                     rst_n_i,
  input logic                     [NumReq-1:0]    req_valid_i,
  input logic                     [NumReq-1:0]    req_ready_o,
  input logic                     [NumReq-1:0]    rsp_valid_o,
  input logic                     [NumBank-1:0]   bank_req_valid_o,
  input logic                     [NumBank-1:0]   bank_req_ready_i,
  input logic                     [NumBank-1:0]   bank_write_o,
  input xbar_types_pkg::addr_t    [NumBank-1:0]   bank_addr_o,
  input xbar_types_pkg::data_t    [NumBank-1:0]   bank_wdata_o,
  input xbar_types_pkg::req_idx_t [NumBank-1:0]   bank_id_o
);
  logic [NumReq-1:0] wait_q;  // Accepted, response still due

  always_ff @(posedge clk_i or negedge rst_n_i) begin : proc_wait
    if (!rst_n_i) begin
      wait_q <= '0;
    end else begin
      wait_q <= (wait_q | (req_valid_i & req_ready_o)) & ~rsp_valid_o;
    end
  end

  for (genvar b = 0; b < NumBank; b++) begin : gen_bank
    a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      bank_req_valid_o[b] && !bank_req_ready_i[b] |=> bank_req_valid_o[b] &&
      $stable({bank_write_o[b], bank_addr_o[b], bank_wdata_o[b], bank_id_o[b]}))
      else $error("Bank %0d request changed while stalled", b);
  end

  for (genvar r = 0; r < NumReq; r++) begin : gen_req
    a_rsp_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_valid_o[r] |=> !rsp_valid_o[r])
      else $error("Requester %0d response longer than one cycle", r);
    a_blocked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wait_q[r] |-> !req_ready_o[r])
      else $error("Requester %0d ready before its response", r);
  end

endmodule : xbar_properties

bind xbar_top xbar_properties #(.NumReq(NumReq), .NumBank(NumBank)) i_props (
  .clk_i            ( clk_i            ),
  .rst_n_i          ( rst_n_i          ),
  .req_valid_i      ( req_valid_i      ),
  .req_ready_o      ( req_ready_o      ),
  .rsp_valid_o      ( rsp_valid_o      ),
  .bank_req_valid_o ( bank_req_valid_o ),
  .bank_req_ready_i ( bank_req_ready_i ),
  .bank_write_o     ( bank_write_o     ),
  .bank_addr_o      ( bank_addr_o      ),
  .bank_wdata_o     ( bank_wdata_o     ),
  .bank_id_o        ( bank_id_o        )
);
